// ==== twin_game.f ====
source/twin_bus_pkg.sv
source/twin_video_pkg.sv
source/twin_main_regs.sv
source/twin_share.sv
source/twin_readback.sv
source/twin_game.sv
tests/twin_game_assertions.sv
tests/tb_twin_game.sv

// ==== Makefile ====
# Verilator flow for the twin board glue: compile, run, clean

VERILATOR ?= verilator
TOP       ?= tb_twin_game
FILELIST  ?= twin_game.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= STATUS: PASS
VFLAGS    ?= --binary --assert -j 0
RUN_FLAGS ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_twin_game.sv ====
// testbench for the twin board glue
// random bus traffic from a fixed seed, checked every cycle against a model
// of the register file, the shared RAM, the video write merger and readback

`timescale 1ns/1ps

module tb_twin_game;
    import twin_bus_pkg::*;
    import twin_video_pkg::*;

    localparam int SH_AW        = 10;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int N_PHASE      = 400;
    localparam int PH_IDLE      = 0;
    localparam int PH_CTRL      = 1;
    localparam int PH_SHARED    = 2;
    localparam int PH_VIDEO     = 3;
    localparam int PH_DEBUG     = 4;
    localparam int PH_MIXED     = 5;
    localparam int TOTAL_CYCLES = RESET_CYCLES + (PH_MIXED + 1) * N_PHASE + 4;
    localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 100) * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        rst;
    cpu_wr_t     main_wr;
    cpu_wr_t     sub_wr;
    logic        tim1;
    logic        tim2;
    logic [3:0]  ioctl_addr;
    logic [7:0]  debug_bus;
    cpu_data_t   main_sh_dout;
    cpu_data_t   sub_sh_dout;
    vram_wr_t    vram_wr;
    logic [7:0]  ioctl_din;
    logic [7:0]  debug_view;

    // reference model state and the outputs expected after the next edge
    cpu_data_t   shadow_ram [2**SH_AW];
    video_regs_t model_regs;
    logic [7:0]  cnt_main;
    logic [7:0]  cnt_share;
    cpu_data_t   exp_main_dout;
    cpu_data_t   exp_sub_dout;
    vram_wr_t    exp_vram;
    logic [7:0]  exp_ioctl;
    logic [7:0]  exp_debug;
    bit          have_exp = 1'b0;
    integer      seed = 34;

    twin_game #(.SH_AW(SH_AW)) u_dut (.*);

    bind twin_share twin_game_assertions u_share_checks (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("Error: time %0t, %s is %0h, expected %0h", $time, name, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic cpu_wr_t rand_wr(input region_t region, input logic [11:0] mask);
        cpu_wr_t w;
        w.addr = {region, 12'($random(seed)) & mask};
        w.data = 16'($random(seed));
        w.we   = 2'($random(seed));
        return w;
    endfunction

    // ioctl byte map of the register file
    function automatic logic [7:0] readback_byte(input video_regs_t r, input logic [3:0] a);
        case (a)
            4'd0: return r.scra_x[7:0];
            4'd1: return r.scrb_x[7:0];
            4'd2: return r.scra_y[7:0];
            4'd3: return r.scrb_y[7:0];
            4'd4: return {r.vflip, r.hflip, r.prio[1:0], r.scrb_y[8], r.scra_y[8],
                          r.scrb_x[8], r.scra_x[8]};
            4'd7: return r.obj_dx[7:0];
            4'd8: return {6'd0, r.obj_dx[9:8]};
            4'd9: return r.obj_dy[7:0];
            4'd10: return {6'd0, r.obj_dy[9:8]};
            default: return 8'd0;
        endcase
    endfunction

    function automatic vram_wr_t vram_from(input cpu_wr_t w);
        vram_wr_t v;
        v      = '0;
        v.addr = w.addr[10:0];
        v.din  = w.data;
        if (w.addr[13:12] == REG_OBJ) begin
            v.obj_we = w.we;
        end else if (w.addr[11]) begin
            v.vb_we = w.we;
        end else begin
            v.va_we = w.we;
        end
        return v;
    endfunction

    // one clock edge of the model, from the inputs about to be sampled
    task automatic predict_next();
        logic [SH_AW-1:0] ma;
        logic [SH_AW-1:0] sa;
        logic             m_req;
        logic             s_req;
        ma    = main_wr.addr[SH_AW-1:0];
        sa    = sub_wr.addr[SH_AW-1:0];
        m_req = (|main_wr.we) && (main_wr.addr[13:12] inside {REG_LAYER, REG_OBJ});
        s_req = (|sub_wr.we) && (sub_wr.addr[13:12] inside {REG_LAYER, REG_OBJ});
        exp_main_dout = shadow_ram[ma];
        exp_sub_dout  = shadow_ram[sa];
        // main bytes land last so they win a collision
        if (sub_wr.addr[13:12] == REG_SHARED) begin
            if (sub_wr.we[1]) shadow_ram[sa][15:8] = sub_wr.data[15:8];
            if (sub_wr.we[0]) shadow_ram[sa][7:0] = sub_wr.data[7:0];
        end
        if (main_wr.addr[13:12] == REG_SHARED) begin
            if (main_wr.we[1]) shadow_ram[ma][15:8] = main_wr.data[15:8];
            if (main_wr.we[0]) shadow_ram[ma][7:0] = main_wr.data[7:0];
        end
        exp_vram = '0;
        if (rst) begin
            exp_ioctl  = 8'd0;
            exp_debug  = 8'd0;
            model_regs = '0;
            cnt_main   = 8'd0;
            cnt_share  = 8'd0;
        end else begin
            // readback sees the registers from before this edge
            exp_ioctl = readback_byte(model_regs, ioctl_addr);
            case (debug_bus[7:6])
                2'd0: exp_debug = cnt_main;
                2'd1: exp_debug = cnt_share;
                2'd2: exp_debug = {6'd0, tim2, tim1};
                default: exp_debug = {7'd0, model_regs.hflip};
            endcase
            if (m_req && tim1) begin
                exp_vram = vram_from(main_wr);
            end else if (s_req && tim2) begin
                exp_vram = vram_from(sub_wr);
            end
            cnt_share = cnt_share + 8'(m_req && !tim1) + 8'(s_req && !tim2);
            if (main_wr.addr[13:12] == REG_CTRL && main_wr.we[0]) begin
                case (main_wr.addr[3:0])
                    4'd0: model_regs.scra_x = main_wr.data[8:0];
                    4'd1: model_regs.scra_y = main_wr.data[8:0];
                    4'd2: model_regs.scrb_x = main_wr.data[8:0];
                    4'd3: model_regs.scrb_y = main_wr.data[8:0];
                    4'd4: model_regs.obj_dx = main_wr.data[9:0];
                    4'd5: model_regs.obj_dy = main_wr.data[9:0];
                    4'd6: begin
                        model_regs.hflip = main_wr.data[0];
                        model_regs.vflip = main_wr.data[1];
                        model_regs.prio  = main_wr.data[4:2];
                    end
                    default: ;
                endcase
                if (main_wr.addr[3:0] <= 4'd6) begin
                    cnt_main = cnt_main + 8'd1;
                end
            end
        end
    endtask

    // outputs are checked mid-cycle, then the model steps one edge
    always @(negedge clk) begin
        if (u_dut.u_share.u_share_checks.fail_count != 0) begin
            $display("a bound assertion on the share block failed");
            $display("STATUS: FAIL");
            $fatal(1, "assertion failure");
        end
        if (have_exp) begin
            check_value("main_sh_dout", 64'(main_sh_dout), 64'(exp_main_dout));
            check_value("sub_sh_dout", 64'(sub_sh_dout), 64'(exp_sub_dout));
            check_value("vram_wr enables", 64'({vram_wr.va_we, vram_wr.vb_we, vram_wr.obj_we}),
                        64'({exp_vram.va_we, exp_vram.vb_we, exp_vram.obj_we}));
            if ({exp_vram.va_we, exp_vram.vb_we, exp_vram.obj_we} != 6'd0) begin
                check_value("vram_wr.addr", 64'(vram_wr.addr), 64'(exp_vram.addr));
                check_value("vram_wr.din", 64'(vram_wr.din), 64'(exp_vram.din));
            end
            check_value("ioctl_din", 64'(ioctl_din), 64'(exp_ioctl));
            check_value("debug_view", 64'(debug_view), 64'(exp_debug));
        end
        predict_next();
        have_exp = 1'b1;
    end

    task automatic drive_cycle(input int phase);
        cpu_wr_t     mw;
        cpu_wr_t     sw;
        region_t     mr;
        region_t     sr;
        logic [1:0]  g;
        logic [11:0] mask;
        mr = 2'($random(seed));
        sr = 2'($random(seed));
        case (phase)
            PH_IDLE, PH_SHARED: begin
                mr = REG_SHARED;
                sr = REG_SHARED;
            end
            PH_CTRL: begin
                mr = REG_CTRL;
                sr = REG_CTRL;
            end
            PH_VIDEO, PH_DEBUG: begin
                // debug phase mixes in control writes to move hflip
                mr = (phase == PH_DEBUG && mr[1]) ? REG_CTRL : (mr[0] ? REG_OBJ : REG_LAYER);
                sr = sr[0] ? REG_OBJ : REG_LAYER;
            end
            default: ;
        endcase
        // shared phase keeps to 64 words so reads hit recent writes
        mask = (phase == PH_SHARED) ? 12'hc3f : 12'hfff;
        mw = rand_wr(mr, mask);
        sw = rand_wr(sr, mask);
        if (phase == PH_IDLE) begin
            mw.we = 2'b00;
            sw.we = 2'b00;
        end
        // same word from both CPUs now and then
        if (($random(seed) & 3) == 0) begin
            sw.addr = mw.addr;
        end
        g = 2'($random(seed));
        if (g == 2'b11) begin
            g = 2'b00;
        end
        @(posedge clk);
        main_wr    <= mw;
        sub_wr     <= sw;
        tim1       <= g[0];
        tim2       <= g[1];
        ioctl_addr <= 4'($random(seed));
        debug_bus  <= 8'($random(seed));
    endtask

    initial begin
        rst        = 1'b1;
        main_wr    = '0;
        sub_wr     = '0;
        tim1       = 1'b0;
        tim2       = 1'b0;
        ioctl_addr = 4'd0;
        debug_bus  = 8'd0;
        for (int i = 0; i < 2**SH_AW; i++) begin
            shadow_ram[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int p = PH_IDLE; p <= PH_MIXED; p++) begin
            repeat (N_PHASE) drive_cycle(p);
        end
        repeat (4) @(negedge clk);
        if (u_dut.u_share.u_share_checks.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("bound assertions on the share block failed %0d times",
                     u_dut.u_share.u_share_checks.fail_count);
            $display("STATUS: FAIL");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// ==== tests/twin_game_assertions.sv ====
// share block assertions
// grant exclusivity and video RAM write strobe rules for the share block

`timescale 1ns/1ps

module twin_game_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   tim1,
    input logic                   tim2,
    input twin_bus_pkg::cpu_wr_t  m_video,
    input twin_bus_pkg::vram_wr_t vram_wr
);
    logic [5:0]  vram_we;
    int unsigned fail_count = 0;

    assign vram_we = {vram_wr.va_we, vram_wr.vb_we, vram_wr.obj_we};

    // grants never overlap in this environment
    grant_exclusive: assert property (@(posedge clk) disable iff (rst) !(tim1 && tim2))
    else begin
        fail_count++;
        $error("tim1 and tim2 high in the same cycle");
    end

    // a granted main write carries its address and data to the port
    main_payload: assert property (@(posedge clk) disable iff (rst)
        tim1 && (|m_video.we) |=> (vram_wr.din == $past(m_video.data)
            && vram_wr.addr == $past(m_video.addr[10:0])))
    else begin
        fail_count++;
        $error("granted main video write has the wrong address or data");
    end

    // no strobe follows a cycle without a grant
    no_grant_idle: assert property (@(posedge clk) disable iff (rst)
        !tim1 && !tim2 |=> vram_we == 6'd0)
    else begin
        fail_count++;
        $error("vram write strobe without a grant");
    end

    main_granted: assert property (@(posedge clk) disable iff (rst)
        tim1 && (|m_video.we) |=> vram_we != 6'd0)
    else begin
        fail_count++;
        $error("granted main video write was lost");
    end

endmodule

// ==== source/twin_game.sv ====
// twin board glue, top level
// main register decoder feeds the shared RAM and video merger,
// and the readback block reports registers and status

`timescale 1ns/1ps

module twin_game #(
    parameter int SH_AW = 10
) (
    input  logic                    clk,
    input  logic                    rst,
    // CPU write buses
    input  twin_bus_pkg::cpu_wr_t   main_wr,
    input  twin_bus_pkg::cpu_wr_t   sub_wr,
    // video RAM access grants
    input  logic                    tim1,
    input  logic                    tim2,
    input  logic [3:0]              ioctl_addr,
    input  logic [7:0]              debug_bus,
    output twin_bus_pkg::cpu_data_t main_sh_dout,
    output twin_bus_pkg::cpu_data_t sub_sh_dout,
    output twin_bus_pkg::vram_wr_t  vram_wr,
    output logic [7:0]              ioctl_din,
    output logic [7:0]              debug_view
);
    import twin_bus_pkg::*;
    import twin_video_pkg::*;

    video_regs_t regs;
    logic [7:0]  st_main;
    logic [7:0]  st_share;
    cpu_wr_t     m_share;
    cpu_wr_t     m_video;

    twin_main_regs u_main_regs (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .main_wr    ( main_wr    ),
        .regs       ( regs       ),
        .st_main    ( st_main    ),
        .m_share    ( m_share    ),
        .m_video    ( m_video    )
    );

    twin_share #(
        .SH_AW      ( SH_AW      )
    ) u_share (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .m_share      ( m_share      ),
        .m_video      ( m_video      ),
        .sub_wr       ( sub_wr       ),
        .tim1         ( tim1         ),
        .tim2         ( tim2         ),
        .main_sh_dout ( main_sh_dout ),
        .sub_sh_dout  ( sub_sh_dout  ),
        .vram_wr      ( vram_wr      ),
        .st_share     ( st_share     )
    );

    twin_readback u_readback (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .regs       ( regs       ),
        .st_main    ( st_main    ),
        .st_share   ( st_share   ),
        .tim1       ( tim1       ),
        .tim2       ( tim2       ),
        .ioctl_addr ( ioctl_addr ),
        .debug_bus  ( debug_bus  ),
        .ioctl_din  ( ioctl_din  ),
        .debug_view ( debug_view )
    );

endmodule

// ==== source/twin_readback.sv ====
// register readback and debug mux
// serves the video registers to the byte-wide ioctl port and
// picks a status byte for the debug view

`timescale 1ns/1ps

module twin_readback (
    input  logic                        clk,
    input  logic                        rst,
    input  twin_video_pkg::video_regs_t regs,
    input  logic [7:0]                  st_main,
    input  logic [7:0]                  st_share,
    input  logic                        tim1,
    input  logic                        tim2,
    input  logic [3:0]                  ioctl_addr,
    input  logic [7:0]                  debug_bus,
    output logic [7:0]                  ioctl_din,
    output logic [7:0]                  debug_view
);

    always_ff @(posedge clk) begin
        if (rst) begin
            ioctl_din <= '0;
        end else begin
            case (ioctl_addr)
                4'd0: ioctl_din <= regs.scra_x[7:0];
                4'd1: ioctl_din <= regs.scrb_x[7:0];
                4'd2: ioctl_din <= regs.scra_y[7:0];
                4'd3: ioctl_din <= regs.scrb_y[7:0];
                // ninth bits of all scrolls packed with flip and priority
                4'd4: ioctl_din <= {regs.vflip, regs.hflip, regs.prio[1:0],
                                    regs.scrb_y[8], regs.scra_y[8],
                                    regs.scrb_x[8], regs.scra_x[8]};
                4'd7: ioctl_din <= regs.obj_dx[7:0];
                4'd8: ioctl_din <= {6'd0, regs.obj_dx[9:8]};
                4'd9: ioctl_din <= regs.obj_dy[7:0];
                4'd10: ioctl_din <= {6'd0, regs.obj_dy[9:8]};
                default: ioctl_din <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            debug_view <= '0;
        end else begin
            case (debug_bus[7:6])
                2'd0: debug_view <= st_main;
                2'd1: debug_view <= st_share;
                2'd2: debug_view <= {6'd0, tim2, tim1};
                default: debug_view <= {7'd0, regs.hflip};
            endcase
        end
    end

endmodule

// ==== source/twin_share.sv ====
// shared work RAM and video RAM write merger
// both CPUs access a byte-enabled work RAM; layer and object writes
// from the CPU that holds the tim1/tim2 grant go out as one stream

`timescale 1ns/1ps

module twin_share #(
    parameter int SH_AW = 10
) (
    input  logic                   clk,
    input  logic                   rst,
    input  twin_bus_pkg::cpu_wr_t  m_share,
    input  twin_bus_pkg::cpu_wr_t  m_video,
    input  twin_bus_pkg::cpu_wr_t  sub_wr,
    input  logic                   tim1,
    input  logic                   tim2,
    output twin_bus_pkg::cpu_data_t main_sh_dout,
    output twin_bus_pkg::cpu_data_t sub_sh_dout,
    output twin_bus_pkg::vram_wr_t  vram_wr,
    output logic [7:0]             st_share
);
    import twin_bus_pkg::*;

    localparam int SH_WORDS = 2**SH_AW;

    cpu_data_t        mem [SH_WORDS];
    logic [SH_AW-1:0] m_idx;
    logic [SH_AW-1:0] s_idx;
    region_t          s_region;
    byte_we_t         s_sh_we;
    logic             m_vid;
    logic             s_vid;
    logic             m_drop;
    logic             s_drop;
    vram_wr_t         nxt;

    // maps a layer or object write onto the video RAM port
    function automatic vram_wr_t to_vram(input cpu_wr_t w);
        vram_wr_t v;
        v        = '0;
        v.addr   = w.addr[10:0];
        v.din    = w.data;
        if (region_of(w.addr) == REG_OBJ) begin
            v.obj_we = w.we;
        end else if (w.addr[LAYER_B_BIT]) begin
            v.vb_we = w.we;
        end else begin
            v.va_we = w.we;
        end
        return v;
    endfunction

    // power-up contents are zero
    initial begin
        for (int i = 0; i < SH_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign m_idx    = m_share.addr[SH_AW-1:0];
    assign s_idx    = sub_wr.addr[SH_AW-1:0];
    assign s_region = region_of(sub_wr.addr);
    assign s_sh_we  = (s_region == REG_SHARED) ? sub_wr.we : 2'b00;

    // read-first ports; main bytes written last so they win a collision
    always_ff @(posedge clk) begin
        main_sh_dout <= mem[m_idx];
        sub_sh_dout  <= mem[s_idx];
        if (s_sh_we[1]) mem[s_idx][15:8] <= sub_wr.data[15:8];
        if (s_sh_we[0]) mem[s_idx][7:0]  <= sub_wr.data[7:0];
        if (m_share.we[1]) mem[m_idx][15:8] <= m_share.data[15:8];
        if (m_share.we[0]) mem[m_idx][7:0]  <= m_share.data[7:0];
    end

    // video requests, sub writes to the register region never count
    assign m_vid  = |m_video.we;
    assign s_vid  = (|sub_wr.we) && (s_region == REG_LAYER || s_region == REG_OBJ);
    assign m_drop = m_vid && !tim1;
    assign s_drop = s_vid && !tim2;

    always_comb begin
        if (m_vid && tim1) begin
            nxt = to_vram(m_video);
        end else if (s_vid && tim2) begin
            nxt = to_vram(sub_wr);
        end else begin
            nxt = '0;
        end
    end

    always_ff @(posedge clk) begin
        vram_wr.addr <= nxt.addr;
        vram_wr.din  <= nxt.din;
        if (rst) begin
            vram_wr.va_we  <= '0;
            vram_wr.vb_we  <= '0;
            vram_wr.obj_we <= '0;
            st_share       <= '0;
        end else begin
            vram_wr.va_we  <= nxt.va_we;
            vram_wr.vb_we  <= nxt.vb_we;
            vram_wr.obj_we <= nxt.obj_we;
            st_share       <= st_share + 8'(m_drop) + 8'(s_drop);
        end
    end

endmodule

// ==== source/twin_main_regs.sv ====
// main CPU register decoder
// turns main CPU writes to the control region into the video
// register file and steers the rest to the shared RAM and video RAM

`timescale 1ns/1ps

module twin_main_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  twin_bus_pkg::cpu_wr_t       main_wr,
    output twin_video_pkg::video_regs_t regs,
    output logic [7:0]                  st_main,
    output twin_bus_pkg::cpu_wr_t       m_share,
    output twin_bus_pkg::cpu_wr_t       m_video
);
    import twin_bus_pkg::*;
    import twin_video_pkg::*;

    region_t  region;
    reg_idx_t idx;
    logic     ctrl_wr;
    logic     idx_ok;

    assign region = region_of(main_wr.addr);
    assign idx    = main_wr.addr[3:0];

    // registers only take the low byte strobe
    assign ctrl_wr = (region == REG_CTRL) && main_wr.we[0];

    always_comb begin
        case (idx)
            IDX_SCRA_X, IDX_SCRA_Y, IDX_SCRB_X, IDX_SCRB_Y,
            IDX_OBJ_DX, IDX_OBJ_DY, IDX_CTRL: idx_ok = 1'b1;
            default: idx_ok = 1'b0;
        endcase
    end

    // pass-through paths, enables masked by region
    always_comb begin
        m_share = main_wr;
        m_video = main_wr;
        if (region != REG_SHARED) begin
            m_share.we = '0;
        end
        if (region != REG_LAYER && region != REG_OBJ) begin
            m_video.we = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            regs    <= '0;
            st_main <= '0;
        end else if (ctrl_wr) begin
            case (idx)
                IDX_SCRA_X: regs.scra_x <= main_wr.data[8:0];
                IDX_SCRA_Y: regs.scra_y <= main_wr.data[8:0];
                IDX_SCRB_X: regs.scrb_x <= main_wr.data[8:0];
                IDX_SCRB_Y: regs.scrb_y <= main_wr.data[8:0];
                IDX_OBJ_DX: regs.obj_dx <= main_wr.data[9:0];
                IDX_OBJ_DY: regs.obj_dy <= main_wr.data[9:0];
                IDX_CTRL: begin
                    regs.hflip <= main_wr.data[CTRL_HFLIP];
                    regs.vflip <= main_wr.data[CTRL_VFLIP];
                    regs.prio  <= main_wr.data[CTRL_PRIO_LSB+:3];
                end
                default: ;
            endcase
            // unused indices are not counted
            if (idx_ok) begin
                st_main <= st_main + 8'd1;
            end
        end
    end

endmodule

// ==== source/twin_video_pkg.sv ====
// twin video package
// widths of the video control registers, the register file struct
// and the register index map of the main CPU control region

package twin_video_pkg;

    typedef logic [8:0] scroll_t;
    typedef logic [9:0] offset_t;
    typedef logic [2:0] prio_t;

    // index into the control region, address bits 3:0
    typedef logic [3:0] reg_idx_t;

    typedef struct packed {
        scroll_t scra_x;
        scroll_t scra_y;
        scroll_t scrb_x;
        scroll_t scrb_y;
        offset_t obj_dx;
        offset_t obj_dy;
        logic    hflip;
        logic    vflip;
        prio_t   prio;
    } video_regs_t;

    localparam reg_idx_t IDX_SCRA_X = 4'd0;
    localparam reg_idx_t IDX_SCRA_Y = 4'd1;
    localparam reg_idx_t IDX_SCRB_X = 4'd2;
    localparam reg_idx_t IDX_SCRB_Y = 4'd3;
    localparam reg_idx_t IDX_OBJ_DX = 4'd4;
    localparam reg_idx_t IDX_OBJ_DY = 4'd5;
    localparam reg_idx_t IDX_CTRL   = 4'd6;

    // bit positions inside the control word
    localparam int CTRL_HFLIP    = 0;
    localparam int CTRL_VFLIP    = 1;
    localparam int CTRL_PRIO_LSB = 2;

endpackage

// ==== source/twin_bus_pkg.sv ====
// twin bus package
// CPU bus widths, the address region map and the write structs
// shared by the main CPU, the sub CPU and the video RAM port

package twin_bus_pkg;

    typedef logic [13:0] cpu_addr_t;
    typedef logic [15:0] cpu_data_t;
    // upper byte first
    typedef logic [1:0]  byte_we_t;
    typedef logic [1:0]  region_t;
    typedef logic [10:0] vram_addr_t;

    typedef struct packed {
        cpu_addr_t addr;
        cpu_data_t data;
        byte_we_t  we;
    } cpu_wr_t;

    typedef struct packed {
        vram_addr_t addr;
        cpu_data_t  din;
        byte_we_t   va_we;
        byte_we_t   vb_we;
        byte_we_t   obj_we;
    } vram_wr_t;

    localparam region_t REG_SHARED = 2'd0;
    localparam region_t REG_LAYER  = 2'd1;
    localparam region_t REG_OBJ    = 2'd2;
    localparam region_t REG_CTRL   = 2'd3;

    // within the layer region this bit picks layer B
    localparam int LAYER_B_BIT = 11;

    function automatic region_t region_of(input cpu_addr_t addr);
        return addr[13:12];
    endfunction

endpackage
